/* all.f */
source/cpu_pkg.sv
source/alu.sv
source/reg_file.sv
source/prog_counter.sv
source/instr_decoder.sv
source/sequencer.sv
source/cpu.sv
testbench/tb_clock.sv
testbench/tb_cpu.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -sv -f all.f --top-module tb_cpu -o tb_cpu_sim
./obj_dir/tb_cpu_sim | tee sim.log

if grep -q "Simulation finished: PASS" sim.log; then
	exit 0
else
	exit 1
fi

/* testbench/tb_cpu.sv */
`default_nettype none

module tb_cpu;

	localparam logic [15:0] RESET_PC = 16'h0200;
	localparam int MAX_TICKS   = 20000;
	localparam int STALL_LIMIT = 64;
	localparam int RESET_LIMIT = 20;

	logic        clk;
	logic        rst_n;
	logic        rst_req;
	logic        rdy_i;
	logic [7:0]  data_i;
	logic [7:0]  data_o;
	logic [15:0] addr_o;
	logic        we_o;
	logic        fetch_o;

	logic [7:0]  mem [0:65535];
	logic [7:0]  mem_ref [0:65535];
	logic [15:0] wp;
	logic [15:0] dp;
	logic [15:0] self_addr;
	logic        stall_mode;

	// Model state
	logic [7:0]  m_a;
	logic [7:0]  m_x;
	logic [7:0]  m_y;
	logic [7:0]  m_p;
	logic [15:0] m_pc;

	// Checker state
	logic        pend;
	logic [15:0] exp_addr;
	logic [7:0]  exp_data;
	logic        first;
	int          self_hits;
	logic        timed_out;
	int          value_errors;
	int          other_errors;
	logic [24:0] trace_ref [$];
	logic [24:0] trace_cur [$];

	tb_clock #(
		.PERIOD       (20),
		.RESET_CYCLES (5)
	) u_clk (
		.rst_req_i (rst_req),
		.clk_o     (clk),
		.rst_n_o   (rst_n)
	);

	cpu #(
		.RESET_PC (RESET_PC)
	) u_dut (
		.clk_i   (clk),
		.rst_n_i (rst_n),
		.rdy_i   (rdy_i),
		.data_i  (data_i),
		.data_o  (data_o),
		.addr_o  (addr_o),
		.we_o    (we_o),
		.fetch_o (fetch_o)
	);

	// Single cycle memory
	assign data_i = mem[addr_o];

	always @(posedge clk) begin
		if (rdy_i && we_o) begin
			mem[addr_o] = data_o;
		end
	end

	// Roughly 70 percent ready in the stalled run
	always @(negedge clk) begin
		if (stall_mode) begin
			rdy_i = ($urandom_range(99, 0) < 70);
		end else begin
			rdy_i = 1'b1;
		end
	end

	task automatic emit1(input logic [7:0] b);
		mem_ref[wp] = b;
		wp = wp + 16'd1;
	endtask

	task automatic emit2(input logic [7:0] op, input logic [7:0] b);
		emit1(op);
		emit1(b);
	endtask

	task automatic store(input logic [7:0] op);
		emit1(op);
		emit1(dp[7:0]);
		emit1(dp[15:8]);
		dp = dp + 16'd1;
	endtask

	// Flag order follows the branch opcode bits N, V, C and Z
	task automatic set_flag(input logic [1:0] f, input logic s);
		case (f)
			2'd0: emit2(8'hA9, s ? 8'h80 : 8'h01);
			2'd1: begin
				emit1(8'h18);
				emit2(8'hA9, s ? 8'h7F : 8'h00);
				emit2(8'h69, s ? 8'h01 : 8'h00);
			end
			2'd2: emit1(s ? 8'h38 : 8'h18);
			default: emit2(8'hA9, s ? 8'h00 : 8'h01);
		endcase
	endtask

	task automatic build_program();
		logic [7:0]  k;
		logic [15:0] t;
		wp = RESET_PC;
		dp = 16'h0800;
		k  = 8'h10;
		// Loads, transfers, inc and dec
		emit2(8'hA9, 8'h05);
		emit2(8'hA2, 8'h80);
		emit2(8'hA0, 8'hFF);
		store(8'h8D);
		store(8'h8E);
		store(8'h8C);
		emit1(8'hE8);
		emit1(8'hC8);
		emit1(8'h88);
		emit1(8'hCA);
		emit1(8'hCA);
		emit1(8'hA8);
		emit1(8'h8A);
		emit1(8'h98);
		emit1(8'hAA);
		store(8'h8D);
		store(8'h8E);
		store(8'h8C);
		// ADC and SBC across carry and overflow
		emit1(8'h18);
		emit2(8'hA9, 8'h7F);
		emit2(8'h69, 8'h01);
		store(8'h8D);
		emit2(8'h69, 8'h80);
		store(8'h8D);
		emit2(8'h69, 8'hFF);
		store(8'h8D);
		emit1(8'h38);
		emit2(8'hE9, 8'h01);
		store(8'h8D);
		emit1(8'h18);
		emit2(8'hE9, 8'h80);
		store(8'h8D);
		emit1(8'h38);
		emit2(8'hA9, 8'h80);
		emit2(8'hE9, 8'h01);
		store(8'h8D);
		emit2(8'h69, 8'h7F);
		store(8'h8D);
		// Logic ops
		emit2(8'hA9, 8'hF0);
		emit2(8'h29, 8'h3C);
		store(8'h8D);
		emit2(8'h09, 8'h81);
		store(8'h8D);
		emit2(8'h49, 8'hFF);
		store(8'h8D);
		// Every branch with the flag both ways around one LDY
		for (int f = 0; f < 4; f++) begin
			for (int v = 0; v < 2; v++) begin
				for (int s = 0; s < 2; s++) begin
					set_flag(f[1:0], s[0]);
					emit2({f[1:0], v[0], 5'b10000}, 8'h02);
					emit2(8'hA0, k);
					k = k + 8'd1;
				end
			end
		end
		store(8'h8C);
		// Backward BNE loop
		emit2(8'hA2, 8'h03);
		emit1(8'hCA);
		emit2(8'hD0, 8'hFD);
		store(8'h8E);
		// JMP over a load and then undefined opcodes
		t = wp + 16'd5;
		emit1(8'h4C);
		emit1(t[7:0]);
		emit1(t[15:8]);
		emit2(8'hA9, 8'hEE);
		emit1(8'h02);
		emit1(8'hFF);
		emit2(8'hA9, 8'h5A);
		store(8'h8D);
		self_addr = wp;
		emit1(8'h4C);
		emit1(self_addr[7:0]);
		emit1(self_addr[15:8]);
	endtask

	task automatic load_image();
		for (int i = 0; i < 65536; i++) begin
			mem_ref[i] = i[7:0] ^ i[15:8] ^ 8'hA5;
		end
		build_program();
		for (int i = 0; i < 65536; i++) begin
			mem[i] = mem_ref[i];
		end
	endtask

	function automatic void set_nz(input logic [7:0] v);
		m_p[7] = v[7];
		m_p[1] = (v == 8'h00);
	endfunction

	// One instruction of the subset; returns the opcode address
	function automatic logic [15:0] ref_step(output logic wr_valid,
		output logic [15:0] wr_addr, output logic [7:0] wr_data);
		logic [15:0] here;
		logic [7:0]  op;
		logic [7:0]  b1;
		logic [7:0]  b2;
		logic [7:0]  addend;
		logic [8:0]  sum;
		logic        flag;
		here     = m_pc;
		op       = mem_ref[here];
		b1       = mem_ref[here + 16'd1];
		b2       = mem_ref[here + 16'd2];
		wr_valid = 1'b0;
		wr_addr  = 16'h0000;
		wr_data  = 8'h00;
		m_pc     = here + 16'd1;
		case (op)
			8'hA9, 8'hA2, 8'hA0: begin
				if (op == 8'hA9) m_a = b1;
				else if (op == 8'hA2) m_x = b1;
				else m_y = b1;
				set_nz(b1);
				m_pc = here + 16'd2;
			end
			8'h69, 8'hE9: begin
				addend = (op == 8'hE9) ? ~b1 : b1;
				sum    = {1'b0, m_a} + {1'b0, addend} + {8'h00, m_p[0]};
				m_p[6] = (((m_a ^ sum[7:0]) & (addend ^ sum[7:0]) & 8'h80) != 8'h00);
				m_p[0] = sum[8];
				m_a    = sum[7:0];
				set_nz(m_a);
				m_pc   = here + 16'd2;
			end
			8'h29, 8'h09, 8'h49: begin
				if (op == 8'h29) m_a = m_a & b1;
				else if (op == 8'h09) m_a = m_a | b1;
				else m_a = m_a ^ b1;
				set_nz(m_a);
				m_pc = here + 16'd2;
			end
			8'h8D, 8'h8E, 8'h8C: begin
				wr_valid = 1'b1;
				wr_addr  = {b2, b1};
				wr_data  = (op == 8'h8D) ? m_a : ((op == 8'h8E) ? m_x : m_y);
				mem_ref[wr_addr] = wr_data;
				m_pc     = here + 16'd3;
			end
			8'hE8: begin
				m_x = m_x + 8'd1;
				set_nz(m_x);
			end
			8'hC8: begin
				m_y = m_y + 8'd1;
				set_nz(m_y);
			end
			8'hCA: begin
				m_x = m_x - 8'd1;
				set_nz(m_x);
			end
			8'h88: begin
				m_y = m_y - 8'd1;
				set_nz(m_y);
			end
			8'hAA: begin
				m_x = m_a;
				set_nz(m_x);
			end
			8'h8A, 8'h98: begin
				m_a = (op == 8'h8A) ? m_x : m_y;
				set_nz(m_a);
			end
			8'hA8: begin
				m_y = m_a;
				set_nz(m_y);
			end
			8'h18: m_p[0] = 1'b0;
			8'h38: m_p[0] = 1'b1;
			8'h4C: m_pc = {b2, b1};
			default: begin
				if (op[4:0] == 5'b10000) begin
					case (op[7:6])
						2'd0:    flag = m_p[7];
						2'd1:    flag = m_p[6];
						2'd2:    flag = m_p[0];
						default: flag = m_p[1];
					endcase
					m_pc = here + 16'd2;
					if (flag == op[5]) begin
						m_pc = m_pc + {{8{b1[7]}}, b1};
					end
				end
			end
		endcase
		return here;
	endfunction

	// Completed bus cycle against the model
	task automatic observe_cycle(input logic stalled, output logic done);
		logic [15:0] fa;
		logic        wv;
		logic [15:0] wa;
		logic [7:0]  wd;
		logic [24:0] entry;
		done = 1'b0;
		if (first) begin
			assert (fetch_o) else begin
				other_errors++;
				$display("First cycle after reset is not an opcode fetch at %0t", $time);
			end
			first = 1'b0;
		end
		if (fetch_o) begin
			assert (!pend) else begin
				other_errors++;
				$display("Expected write to %h never happened", exp_addr);
			end
			fa = ref_step(wv, wa, wd);
			pend     = wv;
			exp_addr = wa;
			exp_data = wd;
			assert (addr_o == fa) else begin
				value_errors++;
				$display("CHECK FAILED t=%0t fetch addr_o expected %h got %h",
					$time, fa, addr_o);
			end
			entry = {1'b0, addr_o, 8'h00};
			if (addr_o == self_addr) begin
				self_hits++;
				done = (self_hits == 2);
			end
		end else if (we_o) begin
			assert (pend) else begin
				other_errors++;
				$display("Unexpected or repeated write to %h at %0t", addr_o, $time);
			end
			assert (addr_o == exp_addr) else begin
				value_errors++;
				$display("CHECK FAILED t=%0t write addr_o expected %h got %h",
					$time, exp_addr, addr_o);
			end
			assert (data_o == exp_data) else begin
				value_errors++;
				$display("CHECK FAILED t=%0t data_o expected %h got %h",
					$time, exp_data, data_o);
			end
			pend  = 1'b0;
			entry = {1'b1, addr_o, data_o};
		end
		if (fetch_o || we_o) begin
			if (stalled) trace_cur.push_back(entry);
			else trace_ref.push_back(entry);
		end
	endtask

	task automatic run_program(input logic stalled);
		int   stall_run;
		int   reset_run;
		logic done;
		m_a       = 8'h00;
		m_x       = 8'h00;
		m_y       = 8'h00;
		m_p       = 8'h20;
		m_pc      = RESET_PC;
		pend      = 1'b0;
		first     = 1'b1;
		self_hits = 0;
		stall_run = 0;
		reset_run = 0;
		done      = 1'b0;
		for (int n = 0; n < MAX_TICKS && !done && !timed_out; n++) begin
			@(negedge clk);
			#1;
			if (!rst_n) begin
				assert (!we_o) else begin
					other_errors++;
					$display("we_o high during reset at %0t", $time);
				end
				reset_run++;
				if (reset_run > RESET_LIMIT) begin
					$display("Timeout: reset never released");
					timed_out = 1'b1;
				end
			end else if (!rdy_i) begin
				stall_run++;
				if (stall_run > STALL_LIMIT) begin
					$display("Timeout: rdy_i stayed low too long");
					timed_out = 1'b1;
				end
			end else begin
				stall_run = 0;
				observe_cycle(stalled, done);
			end
		end
		if (!done && !timed_out) begin
			$display("Timeout: program never reached its final jump");
			timed_out = 1'b1;
		end
	endtask

	initial begin
		rdy_i        = 1'b1;
		rst_req      = 1'b0;
		stall_mode   = 1'b0;
		timed_out    = 1'b0;
		value_errors = 0;
		other_errors = 0;
		void'($urandom(15));
		load_image();
		run_program(1'b0);
		// Second pass with random stalls after a fresh reset
		stall_mode = 1'b1;
		@(posedge clk);
		rst_req = 1'b1;
		@(posedge clk);
		rst_req = 1'b0;
		load_image();
		if (!timed_out) begin
			run_program(1'b1);
		end
		if (!timed_out) begin
			assert (trace_cur.size() == trace_ref.size()) else begin
				other_errors++;
				$display("Stalled run has %0d bus events, unstalled run %0d",
					trace_cur.size(), trace_ref.size());
			end
			for (int i = 0; i < trace_cur.size() && i < trace_ref.size(); i++) begin
				assert (trace_cur[i] == trace_ref[i]) else begin
					value_errors++;
					$display("CHECK FAILED t=%0t bus_event[%0d] expected %h got %h",
						$time, i, trace_ref[i], trace_cur[i]);
				end
			end
		end
		$display("Errors: %0d value mismatches, %0d other failures, timeout %0d",
			value_errors, other_errors, timed_out);
		if (value_errors == 0 && other_errors == 0 && !timed_out) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* testbench/tb_clock.sv */
`default_nettype none

module tb_clock #(
	parameter int PERIOD       = 20,
	parameter int RESET_CYCLES = 5
) (
	input  logic rst_req_i,
	output logic clk_o,
	output logic rst_n_o
);

	int cnt;

	initial begin
		rst_n_o = 1'b0;
		cnt     = RESET_CYCLES;
		clk_o   = 1'b1;
	end

	always #(PERIOD / 2) clk_o = ~clk_o;

	// Reset changes only on falling edges
	always @(negedge clk_o) begin
		if (rst_req_i) begin
			cnt     = RESET_CYCLES;
			rst_n_o = 1'b0;
		end else if (cnt > 0) begin
			cnt = cnt - 1;
			if (cnt == 0) begin
				rst_n_o = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* source/cpu.sv */
`default_nettype none

module cpu import cpu_pkg::*; #(
	parameter logic [15:0] RESET_PC = 16'h0200
) (
	input  logic        clk_i,
	input  logic        rst_n_i,
	input  logic        rdy_i,
	input  logic [7:0]  data_i,
	output logic [7:0]  data_o,
	output logic [15:0] addr_o,
	output logic        we_o,
	output logic        fetch_o
);

	// Sequencer and program counter
	logic [7:0]  opcode;
	logic [7:0]  operand;
	logic        exec;
	logic        pc_inc;
	logic        pc_load;
	logic        pc_rel;
	logic [15:0] jump_addr;
	logic [15:0] pc;

	// Decoded controls
	op_class_t   op_class;
	alu_func_t   alu_func;
	reg_sel_t    src_sel;
	reg_sel_t    dst_sel;
	logic        nz_upd;
	logic        cv_upd;
	carry_op_t   carry_op;
	logic [1:0]  cond_flag;
	logic        cond_value;

	// Datapath
	logic [7:0]  rd_data;
	logic [7:0]  status;
	logic [7:0]  alu_b;
	logic [7:0]  alu_result;
	logic        alu_carry;
	logic        alu_ovf;
	logic        wr_en;
	carry_op_t   carry_op_gated;

	// Immediates take the operand byte, everything else the source register
	assign alu_b = (op_class == IMM) ? operand : rd_data;

	// Register and flag updates only in the last cycle of an instruction
	assign wr_en          = exec && (dst_sel != NONE);
	assign carry_op_gated = exec ? carry_op : KEEP;

	assign data_o = rd_data;

	alu alu0 (
		.func_i     (alu_func),
		.a_i        (rd_data),
		.b_i        (alu_b),
		.carry_i    (status[STATUS_C]),
		.result_o   (alu_result),
		.carry_o    (alu_carry),
		.overflow_o (alu_ovf)
	);

	reg_file regs0 (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.wr_en_i    (wr_en),
		.wr_sel_i   (dst_sel),
		.wr_data_i  (alu_result),
		.nz_upd_i   (exec && nz_upd),
		.cv_upd_i   (exec && cv_upd),
		.carry_i    (alu_carry),
		.overflow_i (alu_ovf),
		.carry_op_i (carry_op_gated),
		.rd_sel_i   (src_sel),
		.rd_data_o  (rd_data),
		.status_o   (status)
	);

	prog_counter #(
		.RESET_PC (RESET_PC)
	) pc0 (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.inc_i       (pc_inc),
		.load_i      (pc_load),
		.load_addr_i (jump_addr),
		.rel_i       (pc_rel),
		.offset_i    (operand),
		.pc_o        (pc)
	);

	instr_decoder idec0 (
		.opcode_i     (opcode),
		.class_o      (op_class),
		.alu_func_o   (alu_func),
		.src_sel_o    (src_sel),
		.dst_sel_o    (dst_sel),
		.nz_upd_o     (nz_upd),
		.cv_upd_o     (cv_upd),
		.carry_op_o   (carry_op),
		.cond_flag_o  (cond_flag),
		.cond_value_o (cond_value)
	);

	sequencer seq0 (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.rdy_i        (rdy_i),
		.data_i       (data_i),
		.pc_i         (pc),
		.status_i     (status),
		.class_i      (op_class),
		.cond_flag_i  (cond_flag),
		.cond_value_i (cond_value),
		.opcode_o     (opcode),
		.operand_o    (operand),
		.exec_o       (exec),
		.pc_inc_o     (pc_inc),
		.pc_load_o    (pc_load),
		.pc_rel_o     (pc_rel),
		.jump_addr_o  (jump_addr),
		.addr_o       (addr_o),
		.we_o         (we_o),
		.fetch_o      (fetch_o)
	);

endmodule

`default_nettype wire

/* source/sequencer.sv */
`default_nettype none

module sequencer import cpu_pkg::*; (
	input  logic        clk_i,
	input  logic        rst_n_i,
	input  logic        rdy_i,
	input  logic [7:0]  data_i,
	input  logic [15:0] pc_i,
	input  logic [7:0]  status_i,
	input  op_class_t   class_i,
	input  logic [1:0]  cond_flag_i,
	input  logic        cond_value_i,
	output logic [7:0]  opcode_o,
	output logic [7:0]  operand_o,
	output logic        exec_o,
	output logic        pc_inc_o,
	output logic        pc_load_o,
	output logic        pc_rel_o,
	output logic [15:0] jump_addr_o,
	output logic [15:0] addr_o,
	output logic        we_o,
	output logic        fetch_o
);

	typedef enum logic [2:0] {
		FETCH,
		OPERAND,
		ADDR_HI,
		WRITE,
		BRANCH
	} state_t;

	state_t     state_q;
	state_t     state_d;
	logic [7:0] opcode_q;
	logic [7:0] operand_q;
	logic [7:0] addr_hi_q;
	logic       cond_bit;
	logic       taken;

	always_comb begin
		case (cond_flag_i)
			2'd0:    cond_bit = status_i[STATUS_N];
			2'd1:    cond_bit = status_i[STATUS_V];
			2'd2:    cond_bit = status_i[STATUS_C];
			default: cond_bit = status_i[STATUS_Z];
		endcase
	end

	assign taken = (cond_bit == cond_value_i);

	always_comb begin
		state_d   = state_q;
		exec_o    = 1'b0;
		pc_inc_o  = 1'b0;
		pc_load_o = 1'b0;
		pc_rel_o  = 1'b0;
		case (state_q)
			FETCH: begin
				pc_inc_o = 1'b1;
				state_d  = OPERAND;
			end
			OPERAND: begin
				case (class_i)
					IMM: begin
						pc_inc_o = 1'b1;
						exec_o   = 1'b1;
						state_d  = FETCH;
					end
					STORE_ABS, JMP_ABS: begin
						pc_inc_o = 1'b1;
						state_d  = ADDR_HI;
					end
					cpu_pkg::BRANCH: begin
						pc_inc_o = 1'b1;
						exec_o   = !taken;
						state_d  = taken ? BRANCH : FETCH;
					end
					// Implied dummy read with the PC held
					default: begin
						exec_o  = 1'b1;
						state_d = FETCH;
					end
				endcase
			end
			ADDR_HI: begin
				if (class_i == JMP_ABS) begin
					pc_load_o = 1'b1;
					exec_o    = 1'b1;
					state_d   = FETCH;
				end else begin
					pc_inc_o = 1'b1;
					state_d  = WRITE;
				end
			end
			WRITE: begin
				exec_o  = 1'b1;
				state_d = FETCH;
			end
			default: begin
				pc_rel_o = 1'b1;
				exec_o   = 1'b1;
				state_d  = FETCH;
			end
		endcase
		// Nothing advances in a stalled bus cycle
		if (!rdy_i) begin
			state_d   = state_q;
			exec_o    = 1'b0;
			pc_inc_o  = 1'b0;
			pc_load_o = 1'b0;
			pc_rel_o  = 1'b0;
		end
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q  <= FETCH;
			opcode_q <= 8'hEA;
		end else if (rdy_i) begin
			state_q <= state_d;
			if (state_q == FETCH) begin
				opcode_q <= data_i;
			end
		end
	end

	// Operand byte doubles as the low address byte
	always_ff @(posedge clk_i) begin
		if (rdy_i && state_q == OPERAND) begin
			operand_q <= data_i;
		end
		if (rdy_i && state_q == ADDR_HI) begin
			addr_hi_q <= data_i;
		end
	end

	assign opcode_o    = opcode_q;
	assign operand_o   = (state_q == OPERAND) ? data_i : operand_q;
	assign jump_addr_o = {data_i, operand_q};
	assign addr_o      = (state_q == WRITE) ? {addr_hi_q, operand_q} : pc_i;
	assign we_o        = (state_q == WRITE);
	assign fetch_o     = (state_q == FETCH);

	// Only a store reaches the write cycle
	assert property (@(posedge clk_i) disable iff (!rst_n_i)
		we_o |-> (class_i == STORE_ABS));

	// Address holds through a stall
	assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!rdy_i |=> $stable(addr_o));

endmodule

`default_nettype wire

/* source/instr_decoder.sv */
`default_nettype none

module instr_decoder import cpu_pkg::*; (
	input  logic [7:0]  opcode_i,
	output op_class_t   class_o,
	output alu_func_t   alu_func_o,
	output reg_sel_t    src_sel_o,
	output reg_sel_t    dst_sel_o,
	output logic        nz_upd_o,
	output logic        cv_upd_o,
	output carry_op_t   carry_op_o,
	output logic [1:0]  cond_flag_o,
	output logic        cond_value_o
);

	// Branch condition is encoded in the opcode itself
	assign cond_flag_o  = opcode_i[7:6];
	assign cond_value_o = opcode_i[5];

	always_comb begin
		// Unknown opcodes fall through as a one byte NOP
		class_o    = IMPLIED;
		alu_func_o = PASS_B;
		src_sel_o  = NONE;
		dst_sel_o  = NONE;
		nz_upd_o   = 1'b0;
		cv_upd_o   = 1'b0;
		carry_op_o = KEEP;

		casez (opcode_i)
			8'hA9: begin class_o = IMM; dst_sel_o = A; nz_upd_o = 1'b1; end
			8'hA2: begin class_o = IMM; dst_sel_o = X; nz_upd_o = 1'b1; end
			8'hA0: begin class_o = IMM; dst_sel_o = Y; nz_upd_o = 1'b1; end
			8'h69, 8'hE9: begin
				class_o    = IMM;
				alu_func_o = opcode_i[7] ? SUB : ADD;
				src_sel_o  = A;
				dst_sel_o  = A;
				nz_upd_o   = 1'b1;
				cv_upd_o   = 1'b1;
			end
			8'h29: begin class_o = IMM; alu_func_o = AND; src_sel_o = A; dst_sel_o = A; nz_upd_o = 1'b1; end
			8'h09: begin class_o = IMM; alu_func_o = OR;  src_sel_o = A; dst_sel_o = A; nz_upd_o = 1'b1; end
			8'h49: begin class_o = IMM; alu_func_o = XOR; src_sel_o = A; dst_sel_o = A; nz_upd_o = 1'b1; end
			8'h8D: begin class_o = STORE_ABS; src_sel_o = A; end
			8'h8E: begin class_o = STORE_ABS; src_sel_o = X; end
			8'h8C: begin class_o = STORE_ABS; src_sel_o = Y; end
			8'hE8: begin alu_func_o = INC; src_sel_o = X; dst_sel_o = X; nz_upd_o = 1'b1; end
			8'hC8: begin alu_func_o = INC; src_sel_o = Y; dst_sel_o = Y; nz_upd_o = 1'b1; end
			8'hCA: begin alu_func_o = DEC; src_sel_o = X; dst_sel_o = X; nz_upd_o = 1'b1; end
			8'h88: begin alu_func_o = DEC; src_sel_o = Y; dst_sel_o = Y; nz_upd_o = 1'b1; end
			// Transfers pass the source through the B input
			8'hAA: begin src_sel_o = A; dst_sel_o = X; nz_upd_o = 1'b1; end
			8'h8A: begin src_sel_o = X; dst_sel_o = A; nz_upd_o = 1'b1; end
			8'hA8: begin src_sel_o = A; dst_sel_o = Y; nz_upd_o = 1'b1; end
			8'h98: begin src_sel_o = Y; dst_sel_o = A; nz_upd_o = 1'b1; end
			8'h18: carry_op_o = CLEAR;
			8'h38: carry_op_o = SET;
			8'h4C: class_o = JMP_ABS;
			8'b???1_0000: class_o = BRANCH;
			default: ;
		endcase
	end

endmodule

`default_nettype wire

/* source/prog_counter.sv */
`default_nettype none

module prog_counter #(
	parameter logic [15:0] RESET_PC = 16'h0200
) (
	input  logic              clk_i,
	input  logic              rst_n_i,
	input  logic              inc_i,
	input  logic              load_i,
	input  logic [15:0]       load_addr_i,
	input  logic              rel_i,
	input  logic signed [7:0] offset_i,
	output logic [15:0]       pc_o
);

	logic [15:0] pc_q;
	logic [15:0] offset_ext;

	assign offset_ext = {{8{offset_i[7]}}, offset_i};

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			pc_q <= RESET_PC;
		end else if (load_i) begin
			pc_q <= load_addr_i;
		end else if (rel_i) begin
			// Relative to the address after the offset byte
			pc_q <= pc_q + offset_ext;
		end else if (inc_i) begin
			pc_q <= pc_q + 16'h0001;
		end
	end

	assign pc_o = pc_q;

	// Sequencer issues at most one PC action per cycle
	assert property (@(posedge clk_i) disable iff (!rst_n_i)
		$onehot0({inc_i, load_i, rel_i}));

endmodule

`default_nettype wire

/* source/reg_file.sv */
`default_nettype none

module reg_file import cpu_pkg::*; (
	input  logic        clk_i,
	input  logic        rst_n_i,
	input  logic        wr_en_i,
	input  reg_sel_t    wr_sel_i,
	input  logic [7:0]  wr_data_i,
	input  logic        nz_upd_i,
	input  logic        cv_upd_i,
	input  logic        carry_i,
	input  logic        overflow_i,
	input  carry_op_t   carry_op_i,
	input  reg_sel_t    rd_sel_i,
	output logic [7:0]  rd_data_o,
	output logic [7:0]  status_o
);

	// Bit 5 of the status byte is never written
	localparam logic [7:0] P_RESET = 8'h20;

	logic [7:0] a_q;
	logic [7:0] x_q;
	logic [7:0] y_q;
	logic [7:0] p_q;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			a_q <= 8'h00;
			x_q <= 8'h00;
			y_q <= 8'h00;
			p_q <= P_RESET;
		end else begin
			if (wr_en_i) begin
				case (wr_sel_i)
					A: a_q <= wr_data_i;
					X: x_q <= wr_data_i;
					Y: y_q <= wr_data_i;
					default: ;
				endcase
			end
			// N and Z follow the value being written
			if (nz_upd_i) begin
				p_q[STATUS_N] <= wr_data_i[7];
				p_q[STATUS_Z] <= (wr_data_i == 8'h00);
			end
			if (cv_upd_i) begin
				p_q[STATUS_C] <= carry_i;
				p_q[STATUS_V] <= overflow_i;
			end
			case (carry_op_i)
				SET:   p_q[STATUS_C] <= 1'b1;
				CLEAR: p_q[STATUS_C] <= 1'b0;
				default: ;
			endcase
		end
	end

	always_comb begin
		case (rd_sel_i)
			A:       rd_data_o = a_q;
			X:       rd_data_o = x_q;
			Y:       rd_data_o = y_q;
			default: rd_data_o = 8'h00;
		endcase
	end

	assign status_o = p_q;

	// Write strobe from the top level must pair with a decoded destination
	assert property (@(posedge clk_i) disable iff (!rst_n_i)
		wr_en_i |-> (wr_sel_i != NONE));

endmodule

`default_nettype wire

/* source/alu.sv */
`default_nettype none

module alu import cpu_pkg::*; (
	input  alu_func_t   func_i,
	input  logic [7:0]  a_i,
	input  logic [7:0]  b_i,
	input  logic        carry_i,
	output logic [7:0]  result_o,
	output logic        carry_o,
	output logic        overflow_o
);

	logic [7:0] b_eff;
	logic [8:0] sum;

	// Subtract is add of the inverted operand, carry acts as not-borrow
	assign b_eff = (func_i == SUB) ? ~b_i : b_i;
	assign sum = {1'b0, a_i} + {1'b0, b_eff} + {8'h00, carry_i};

	assign carry_o = sum[8];
	// Signed overflow when both inputs agree in sign and the result does not
	assign overflow_o = (a_i[7] == b_eff[7]) && (sum[7] != a_i[7]);

	always_comb begin
		case (func_i)
			ADD, SUB: begin
				result_o = sum[7:0];
			end
			AND: begin
				result_o = a_i & b_i;
			end
			OR: begin
				result_o = a_i | b_i;
			end
			XOR: begin
				result_o = a_i ^ b_i;
			end
			INC: begin
				result_o = a_i + 8'h01;
			end
			DEC: begin
				result_o = a_i - 8'h01;
			end
			default: begin
				result_o = b_i;
			end
		endcase
	end

endmodule

`default_nettype wire

/* source/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

	// ALU operation select
	typedef enum logic [2:0] {
		ADD    = 3'd0,
		SUB    = 3'd1,
		AND    = 3'd2,
		OR     = 3'd3,
		XOR    = 3'd4,
		INC    = 3'd5,
		DEC    = 3'd6,
		PASS_B = 3'd7
	} alu_func_t;

	// Register select, NONE means no register
	typedef enum logic [1:0] {
		NONE = 2'd0,
		A    = 2'd1,
		X    = 2'd2,
		Y    = 2'd3
	} reg_sel_t;

	// Instruction class, sets the bus cycle sequence
	typedef enum logic [2:0] {
		IMM       = 3'd0,
		STORE_ABS = 3'd1,
		IMPLIED   = 3'd2,
		JMP_ABS   = 3'd3,
		BRANCH    = 3'd4
	} op_class_t;

	// Direct carry flag action
	typedef enum logic [1:0] {
		KEEP  = 2'd0,
		SET   = 2'd1,
		CLEAR = 2'd2
	} carry_op_t;

	// Flag positions in the status byte
	localparam int STATUS_C = 0;
	localparam int STATUS_Z = 1;
	localparam int STATUS_V = 6;
	localparam int STATUS_N = 7;

endpackage

`default_nettype wire
